/* hw/digit_defs.svh */
`ifndef DIGIT_DEFS_SVH
`define DIGIT_DEFS_SVH

// frame decimation
`define DS_STEP 4            // keep one pixel in 4, columns and rows

// classifier result
`define NUM_CLASSES 10       // scores per image, one per digit class

// seven-segment display
`define SEG_DIGITS 6         // digits on the board
`define SEG_SCAN_DIV 16      // cycles per digit, short for sim

// on hardware the scan divider would be in the thousands
// so each digit is lit for a few hundred microseconds

`endif

/* hw/digit_pkg.sv */
`default_nettype none

`include "digit_defs.svh"

package digit_pkg;

  // raw camera byte bus, sync to clk_25m
  typedef struct packed {
    logic       vsync;      // frame sync
    logic       href;       // line valid
    logic [7:0] data;       // byte, high then low per pixel
  } cam_bus_t;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    logic    valid;         // one-cycle strobe
    logic    sof;           // first pixel of frame
    rgb565_t pixel;
  } pix_beat_t;

  // gray stream, also the classifier feed
  typedef struct packed {
    logic       valid;
    logic       sof;
    logic [7:0] data;       // 8-bit luma
  } gray_beat_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;       // class score from network
  } score_beat_t;

  typedef struct packed {
    logic       valid;
    logic [3:0] idx;        // winning class
  } class_beat_t;

  typedef struct packed {
    logic [`SEG_DIGITS-1:0] sel_n;  // digit select, active low
    logic [7:0]             data;   // segments dp..a, active low
  } seg_drive_t;

endpackage

`default_nettype wire

/* hw/cam_byte_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_byte_pack (
  input  wire                  clk_25m,
  input  wire                  rst_n,
  input  wire digit_pkg::cam_bus_t cam,
  output digit_pkg::pix_beat_t pix
);

  logic        phase;       // 1 once high byte is held
  logic [7:0]  hi_byte;     // first byte of pair
  logic        vsync_d;     // last vsync for edge detect
  logic        sof_arm;     // next pixel starts a frame
  logic        vsync_rise;
  logic        pair_done;   // second byte sampled this cycle
  logic        pix_valid;
  logic        pix_sof;
  logic [15:0] pix_word;    // packed rgb565 word

  assign vsync_rise = cam.vsync & ~vsync_d;
  assign pair_done  = cam.href & phase;

  // control path
  always_ff @(posedge clk_25m or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= 1'b0;
      vsync_d   <= 1'b0;
      sof_arm   <= 1'b0;
      pix_valid <= 1'b0;
      pix_sof   <= 1'b0;
    end else begin
      vsync_d   <= cam.vsync;
      pix_valid <= pair_done;
      pix_sof   <= pair_done & sof_arm;
      if (!cam.href) begin
        phase <= 1'b0;                  // byte pairing restarts each line
      end else begin
        phase <= ~phase;
      end
      if (vsync_rise) begin
        sof_arm <= 1'b1;
      end else if (pair_done) begin
        sof_arm <= 1'b0;                // consumed by first pixel
      end
    end
  end

  // pixel payload
  always_ff @(posedge clk_25m) begin
    if (cam.href && !phase) begin
      hi_byte <= cam.data;              // high byte first
    end
    if (pair_done) begin
      pix_word <= {hi_byte, cam.data};
    end
  end

  assign pix = {pix_valid, pix_sof, pix_word};

endmodule

`default_nettype wire

/* hw/gray_convert.sv */
`timescale 1ns/1ps
`default_nettype none

module gray_convert (
  input  wire                      clk_25m,
  input  wire                      rst_n,
  input  wire digit_pkg::pix_beat_t pix,
  output digit_pkg::gray_beat_t    gray
);

  logic [7:0]  r8;           // channels padded to 8 bits
  logic [7:0]  g8;
  logic [7:0]  b8;
  logic        s1_valid;
  logic        s1_sof;
  logic [15:0] s1_sum;       // weighted sum, max 65280
  logic        s2_valid;
  logic        s2_sof;
  logic [7:0]  s2_gray;

  // low bits zero filled, same as display path
  assign r8 = {pix.pixel.r, 3'b000};
  assign g8 = {pix.pixel.g, 2'b00};
  assign b8 = {pix.pixel.b, 3'b000};

  always_ff @(posedge clk_25m or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_sof   <= 1'b0;
      s2_valid <= 1'b0;
      s2_sof   <= 1'b0;
    end else begin
      s1_valid <= pix.valid;
      s1_sof   <= pix.valid & pix.sof;
      s2_valid <= s1_valid;
      s2_sof   <= s1_sof;
    end
  end

  always_ff @(posedge clk_25m) begin
    if (pix.valid) begin
      // 0.299 / 0.587 / 0.114 scaled by 256
      s1_sum <= 16'(r8) * 16'd77 + 16'(g8) * 16'd150 + 16'(b8) * 16'd29;
    end
    if (s1_valid) begin
      s2_gray <= s1_sum[15:8];  // divide by 256, truncate
    end
  end

  assign gray = {s2_valid, s2_sof, s2_gray};

endmodule

`default_nettype wire

/* hw/frame_decimate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "digit_defs.svh"

module frame_decimate (
  input  wire                       clk_25m,
  input  wire                       rst_n,
  input  wire                       href,
  input  wire digit_pkg::gray_beat_t gray,
  output digit_pkg::gray_beat_t     cls_in
);

  localparam int PH_W = $clog2(`DS_STEP);

  logic [3:0]      href_sr;   // href delayed to line up with gray beats
  logic            row_end;
  logic [PH_W-1:0] col_ph;    // column position mod DS_STEP
  logic [PH_W-1:0] row_ph;    // row position mod DS_STEP
  logic [PH_W-1:0] col_eff;
  logic [PH_W-1:0] row_eff;
  logic            keep;
  logic            out_valid;
  logic            out_sof;
  logic [7:0]      out_data;

  function automatic logic [PH_W-1:0] ph_step(input logic [PH_W-1:0] ph);
    ph_step = (ph == PH_W'(`DS_STEP - 1)) ? '0 : ph + 1'b1;
  endfunction

  // last beat of a line lands 3 cycles after href drops, row_end one later
  assign row_end = href_sr[3] & ~href_sr[2];
  assign col_eff = gray.sof ? '0 : col_ph;   // frame start forces origin
  assign row_eff = gray.sof ? '0 : row_ph;
  assign keep    = gray.valid && (col_eff == '0) && (row_eff == '0);

  always_ff @(posedge clk_25m or negedge rst_n) begin
    if (!rst_n) begin
      href_sr   <= '0;
      col_ph    <= '0;
      row_ph    <= '0;
      out_valid <= 1'b0;
      out_sof   <= 1'b0;
    end else begin
      href_sr   <= {href_sr[2:0], href};
      out_valid <= keep;
      out_sof   <= keep & gray.sof;  // sof pixel always sits on the grid
      if (row_end) begin
        col_ph <= '0;
        row_ph <= ph_step(row_ph);
      end else if (gray.valid) begin
        col_ph <= ph_step(col_eff);
        row_ph <= row_eff;
      end
    end
  end

  always_ff @(posedge clk_25m) begin
    if (keep) begin
      out_data <= gray.data;
    end
  end

  assign cls_in = {out_valid, out_sof, out_data};

endmodule

`default_nettype wire

/* hw/max_prob_finder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "digit_defs.svh"

module max_prob_finder (
  input  wire                        clk_25m,
  input  wire                        rst_n,
  input  wire digit_pkg::score_beat_t score,
  output digit_pkg::class_beat_t     result
);

  logic [3:0] cnt;        // score position in group
  logic [7:0] best_val;   // running max
  logic [3:0] best_idx;
  logic       take;       // this score becomes the best
  logic       last;       // last score of the group
  logic       res_valid;
  logic [3:0] res_idx;

  // strictly greater only so ties keep the lower index
  assign take = (cnt == 4'd0) || (score.data > best_val);
  assign last = (cnt == 4'(`NUM_CLASSES - 1));

  always_ff @(posedge clk_25m or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= 4'd0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= score.valid & last;
      if (score.valid) begin
        cnt <= last ? 4'd0 : cnt + 4'd1;
      end
    end
  end

  // best score tracking and group result
  always_ff @(posedge clk_25m) begin
    if (score.valid && take) begin
      best_val <= score.data;
      best_idx <= cnt;
    end
    if (score.valid && last) begin
      res_idx <= take ? cnt : best_idx;   // include the last score itself
    end
  end

  assign result = {res_valid, res_idx};

endmodule

`default_nettype wire

/* hw/seg_led.sv */
`timescale 1ns/1ps
`default_nettype none

`include "digit_defs.svh"

module seg_led (
  input  wire                    clk_25m,
  input  wire                    rst_n,
  input  wire [3:0]              num,
  output digit_pkg::seg_drive_t  seg
);

  localparam int DIV_W = $clog2(`SEG_SCAN_DIV);
  localparam int DIG_W = $clog2(`SEG_DIGITS);

  logic [DIV_W-1:0]       div_cnt;   // dwell time per digit
  logic [DIG_W-1:0]       dig;       // active digit, 0 is rightmost
  logic                   div_end;
  logic [7:0]             num_pat;   // decoded segments of num
  logic [`SEG_DIGITS-1:0] sel_n;
  logic [7:0]             seg_data;

  assign div_end = (div_cnt == DIV_W'(`SEG_SCAN_DIV - 1));

  always_ff @(posedge clk_25m or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      dig     <= '0;
    end else begin
      div_cnt <= div_end ? '0 : div_cnt + 1'b1;
      if (div_end) begin
        if (dig == DIG_W'(`SEG_DIGITS - 1)) begin
          dig <= '0;                         // wrap back to digit 0
        end else begin
          dig <= dig + 1'b1;
        end
      end
    end
  end

  // common anode, segment on when low, dp kept off
  always_comb begin
    case (num)
      4'd0:    num_pat = 8'hC0;
      4'd1:    num_pat = 8'hF9;
      4'd2:    num_pat = 8'hA4;
      4'd3:    num_pat = 8'hB0;
      4'd4:    num_pat = 8'h99;
      4'd5:    num_pat = 8'h92;
      4'd6:    num_pat = 8'h82;
      4'd7:    num_pat = 8'hF8;
      4'd8:    num_pat = 8'h80;
      4'd9:    num_pat = 8'h90;
      default: num_pat = 8'hFF;              // out of range, blank
    endcase
  end

  assign sel_n    = ~(`SEG_DIGITS'(1) << dig);
  assign seg_data = (dig == '0) ? num_pat : 8'hFF;  // only digit 0 used
  assign seg      = {sel_n, seg_data};

endmodule

`default_nettype wire

/* hw/digit_view_top.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_view_top (
  input  wire                         clk_25m,
  input  wire                         rst_n,
  input  wire digit_pkg::cam_bus_t    cam,
  input  wire digit_pkg::score_beat_t score,
  output digit_pkg::gray_beat_t       cls_in,
  output digit_pkg::seg_drive_t       seg
);

  import digit_pkg::*;

  pix_beat_t   pix;       // packed camera pixels
  gray_beat_t  gray;      // full-rate gray stream
  class_beat_t result;    // argmax strobe per image
  logic [3:0]  shown;     // class on the display

  cam_byte_pack u_cam_byte_pack (
    .clk_25m (clk_25m),
    .rst_n   (rst_n),
    .cam     (cam),
    .pix     (pix)
  );

  gray_convert u_gray_convert (
    .clk_25m (clk_25m),
    .rst_n   (rst_n),
    .pix     (pix),
    .gray    (gray)
  );

  // raw href marks line ends, delay handled inside
  frame_decimate u_frame_decimate (
    .clk_25m (clk_25m),
    .rst_n   (rst_n),
    .href    (cam.href),
    .gray    (gray),
    .cls_in  (cls_in)
  );

  max_prob_finder u_max_prob_finder (
    .clk_25m (clk_25m),
    .rst_n   (rst_n),
    .score   (score),
    .result  (result)
  );

  // hold last result until the next image
  always_ff @(posedge clk_25m or negedge rst_n) begin
    if (!rst_n) begin
      shown <= 4'd0;
    end else if (result.valid) begin
      shown <= result.idx;
    end
  end

  seg_led u_seg_led (
    .clk_25m (clk_25m),
    .rst_n   (rst_n),
    .num     (shown),
    .seg     (seg)
  );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_25m,
  output logic rst_n
);

  initial begin
    clk_25m = 1'b0;
    forever #20 clk_25m = ~clk_25m;  // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk_25m);   // 8 cycles in reset
    @(negedge clk_25m);
    rst_n = 1'b1;                    // release away from the active edge
  end

endmodule

`default_nettype wire

/* verification/tb_digit_view.sv */
`timescale 1ns/1ps
`default_nettype none

`include "digit_defs.svh"

module tb_digit_view;

  import digit_pkg::*;

  typedef struct packed {
    logic        sof;
    logic [7:0]  data;
    logic [31:0] cyc;     // edge at which a consumer takes the beat
  } exp_beat_t;

  localparam int CLK_NS    = 40;
  localparam int SCAN_CYC  = `SEG_DIGITS * `SEG_SCAN_DIV;
  localparam int FRAME_CYC = 8 + 8 * (16 * 2 + 4) + 20;    // vsync, rows, drain
  localparam int GROUP_CYC = `NUM_CLASSES + 2 + SCAN_CYC;
  localparam int RUN_CYC   = 8 + SCAN_CYC + 4 * FRAME_CYC + 10 * GROUP_CYC;

  logic        clk_25m;
  logic        rst_n;
  cam_bus_t    cam;
  score_beat_t score;
  gray_beat_t  cls_in;
  seg_drive_t  seg;

  exp_beat_t   exp_q[$];          // beats still due on cls_in
  integer      seed = 32'hc9c0;
  logic [31:0] cyc;               // edge counter
  int          beats;             // cls_in beats seen so far
  int          mon_errors;
  int          chk_errors;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen u_clock_gen (.clk_25m(clk_25m), .rst_n(rst_n));

  digit_view_top dut_i (
    .clk_25m (clk_25m),
    .rst_n   (rst_n),
    .cam     (cam),
    .score   (score),
    .cls_in  (cls_in),
    .seg     (seg)
  );

  always @(posedge clk_25m or negedge rst_n) begin
    if (!rst_n) cyc <= '0;
    else        cyc <= cyc + 32'd1;
  end

  // luma with each channel zero padded to 8 bits
  function automatic logic [7:0] ref_gray(input logic [7:0] hi, input logic [7:0] lo);
    int r8;
    int g8;
    int b8;
    r8 = int'(hi[7:3]) * 8;
    g8 = int'({hi[2:0], lo[7:5]}) * 4;
    b8 = int'(lo[4:0]) * 8;
    return 8'((r8 * 77 + g8 * 150 + b8 * 29) / 256);
  endfunction

  function automatic logic on_grid(input int col, input int row);
    return (col % `DS_STEP == 0) && (row % `DS_STEP == 0);
  endfunction

  // first of the equal maxima wins
  function automatic logic [3:0] ref_argmax(input logic [7:0] s [`NUM_CLASSES]);
    int best;
    best = 0;
    for (int i = 1; i < `NUM_CLASSES; i++) begin
      if (s[i] > s[best]) best = i;
    end
    return 4'(best);
  endfunction

  // segments gfedcba lit high, inverted for common anode
  function automatic logic [7:0] seg_pattern(input logic [3:0] d);
    case (d)
      4'd0: return ~8'h3F;
      4'd1: return ~8'h06;
      4'd2: return ~8'h5B;
      4'd3: return ~8'h4F;
      4'd4: return ~8'h66;
      4'd5: return ~8'h6D;
      4'd6: return ~8'h7D;
      4'd7: return ~8'h07;
      4'd8: return ~8'h7F;
      4'd9: return ~8'h6F;
      default: return 8'hFF;         // nothing lit
    endcase
  endfunction

  function automatic int err_total();
    return mon_errors + chk_errors;
  endfunction

  // compare process, one pop per cls_in strobe
  always @(negedge clk_25m) begin : compare_beats
    exp_beat_t want;
    if (rst_n && cls_in.valid) begin
      beats++;
      assert (exp_q.size() > 0) else begin
        $display("Error at %0t: unexpected cls_in beat, data %h", $time, cls_in.data);
        mon_errors++;
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        assert (cls_in.data == want.data && cls_in.sof == want.sof) else begin
          $display("Error at %0t: cls_in data %h sof %b, expected %h sof %b",
                   $time, cls_in.data, cls_in.sof, want.data, want.sof);
          mon_errors++;
        end
        assert (cyc + 32'd1 == want.cyc) else begin
          $display("Error at %0t: beat taken at edge %0d, expected edge %0d",
                   $time, cyc + 32'd1, want.cyc);
          mon_errors++;
        end
      end
    end
  end

  // one vsync pulse then rows of byte pairs, marker frame lights one grid pixel
  task automatic drive_frame(input int cols, input int rows, input logic marker);
    logic [31:0] rnd;
    logic [15:0] px;
    exp_beat_t   e;
    @(negedge clk_25m);
    cam.vsync = 1'b1;
    repeat (2) @(negedge clk_25m);
    cam.vsync = 1'b0;
    repeat (4) @(negedge clk_25m);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        rnd = $random(seed);
        if (marker) px = (r == 4 && c == 8) ? 16'hFFFF : 16'h0000;
        else        px = rnd[15:0];
        cam.href = 1'b1;
        cam.data = px[15:8];          // high byte first
        @(negedge clk_25m);
        cam.data = px[7:0];
        if (on_grid(c, r)) begin
          e.sof  = (r == 0 && c == 0);
          e.data = ref_gray(px[15:8], px[7:0]);
          e.cyc  = cyc + 32'd1 + 32'd4;  // low byte taken next edge, 4 edges of latency
          exp_q.push_back(e);
        end
        @(negedge clk_25m);
      end
      cam.href = 1'b0;
      repeat (4) @(negedge clk_25m);  // line gap
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 16) begin
      @(negedge clk_25m);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%0d expected cls_in beats never came out", exp_q.size());
      chk_errors++;
    end
    exp_q.delete();
    repeat (4) @(negedge clk_25m);
  endtask

  task automatic check_count(input int got, input int want);
    assert (got == want) else begin
      $display("Error at %0t: %0d cls_in beats, expected %0d", $time, got, want);
      chk_errors++;
    end
  endtask

  // one full scan, digit 0 carries the class, the rest stay blank
  task automatic check_display(input logic [3:0] d);
    int         seen;
    logic [7:0] want;
    seen = 0;
    repeat (SCAN_CYC) begin
      @(negedge clk_25m);
      if (seg.sel_n == ~`SEG_DIGITS'(1)) begin
        want = seg_pattern(d);
        seen++;
      end else begin
        want = 8'hFF;
      end
      assert (seg.data == want && $onehot(~seg.sel_n)) else begin
        $display("Error at %0t: select %b shows %h, expected %h",
                 $time, seg.sel_n, seg.data, want);
        chk_errors++;
      end
    end
    assert (seen == `SEG_SCAN_DIV) else begin
      $display("digit 0 was selected %0d cycles in one scan instead of %0d",
               seen, `SEG_SCAN_DIV);
      chk_errors++;
    end
  endtask

  task automatic run_group(input logic [7:0] s [`NUM_CLASSES]);
    for (int i = 0; i < `NUM_CLASSES; i++) begin
      score.valid = 1'b1;
      score.data  = s[i];
      @(negedge clk_25m);
    end
    score.valid = 1'b0;
    repeat (2) @(negedge clk_25m);    // result strobe, then shown register
    check_display(ref_argmax(s));
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (err_total() == err_start) begin
      $display("[%0t] %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: FAILED, %0d errors", $time, name, err_total() - err_start);
    end
  endtask

  initial begin
    logic [7:0]  s [`NUM_CLASSES];
    logic [31:0] rnd;
    int          err_start;
    int          start;
    int          n1;
    cam   = '0;
    score = '0;
    @(posedge rst_n);
    @(negedge clk_25m);

    err_start = err_total();
    assert (cls_in.valid == 1'b0) else begin
      $display("Error at %0t: cls_in valid high right after reset", $time);
      chk_errors++;
    end
    check_display(4'd0);
    finish_test("reset state", err_start);

    err_start = err_total();
    start = beats;
    drive_frame(16, 8, 1'b0);
    wait_drain();
    check_count(beats - start, 8);     // 4 columns by 2 rows
    finish_test("random 16x8 frame", err_start);

    err_start = err_total();
    start = beats;
    drive_frame(16, 8, 1'b1);          // bright pixel at row 4, column 8
    wait_drain();
    check_count(beats - start, 8);
    finish_test("pixel latency", err_start);

    err_start = err_total();
    for (int g = 0; g < 8; g++) begin
      for (int i = 0; i < `NUM_CLASSES; i++) begin
        rnd  = $random(seed);
        s[i] = rnd[7:0];
      end
      run_group(s);
    end
    finish_test("random score groups", err_start);

    err_start = err_total();
    foreach (s[i]) s[i] = 8'h40;
    s[5] = 8'hD0;
    s[8] = 8'hD0;                      // tie between 5 and 8
    run_group(s);
    foreach (s[i]) s[i] = 8'h77;       // all equal, class 0 wins
    run_group(s);
    finish_test("tied scores", err_start);

    err_start = err_total();
    start = beats;
    drive_frame(14, 6, 1'b0);          // rows and columns off the step
    wait_drain();
    n1 = beats - start;
    check_count(n1, 8);
    start = beats;
    drive_frame(14, 6, 1'b0);
    wait_drain();
    check_count(beats - start, n1);
    finish_test("back to back frames", err_start);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_total());
    if (tests_failed == 0 && err_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog, twice the expected run length
  initial begin
    #(2 * RUN_CYC * CLK_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/digit_pkg.sv
hw/cam_byte_pack.sv
hw/gray_convert.sv
hw/frame_decimate.sv
hw/max_prob_finder.sv
hw/seg_led.sv
hw/digit_view_top.sv
verification/tb_clock_gen.sv
verification/tb_digit_view.sv

/* Makefile */
SIM_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_digit_view -f tb.f --Mdir $(SIM_DIR)
	@out="$$(./$(SIM_DIR)/Vtb_digit_view)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(SIM_DIR)
